// File: Makefile
.PHONY: sim clean

# Build with Verilator and look for the pass line in the simulator output
sim:
	verilator --binary --timing --assert --top-module mips_soc_tb -f mips_soc.f -o mips_soc_sim
	./obj_dir/mips_soc_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: dv/mips_soc_tb.sv
`timescale 1ns/1ps

module mips_soc_tb;

  localparam int clk_period = 10;
  localparam int num_rows = 6;
  localparam int prog_len = 12;
  localparam int poll_limit = 80;
  // APB transfers per row besides the status polls
  localparam int row_txns = 24;
  localparam int apb_cycles = 3;
  localparam int timeout_ns = (num_rows * (row_txns + poll_limit) + 16) * apb_cycles * clk_period;
  localparam logic [31:0] sentinel = 32'hdead_beef;

  logic clk;
  logic reset;
  logic [mips_pkg::apb_addr_w-1:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;

  // Program table with expected results
  logic [31:0] prog [num_rows][prog_len];
  logic [31:0] exp_v0 [num_rows];
  logic [31:0] exp_data [num_rows];
  logic [7:0] data_idx [num_rows];
  int errors = 0;
  int checks = 0;

  mips_soc uut (
    .clk     (clk),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(timeout_ns);
    $display("Timeout: the run did not finish within %0d ns", timeout_ns);
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic logic [31:0] r_format(input int rs, input int rt, input int rd,
                                           input int shamt, input logic [5:0] fn);
    return {mips_pkg::op_special, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], fn};
  endfunction

  function automatic logic [31:0] i_format(input logic [5:0] op, input int rs, input int rt,
                                           input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  function automatic logic [31:0] j_format(input logic [5:0] op, input int target);
    return {op, target[25:0]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    paddr <= addr;
    pwdata <= data;
    pwrite <= 1'b1;
    psel <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    check_value($sformatf("pready on write to 0x%02h", addr), {31'b0, pready}, 32'h1);
    check_value($sformatf("pslverr on write to 0x%02h", addr), {31'b0, pslverr}, 32'h0);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    paddr <= addr;
    pwrite <= 1'b0;
    psel <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    check_value($sformatf("pready on read from 0x%02h", addr), {31'b0, pready}, 32'h1);
    // Response was captured in setup and holds through this edge
    data = prdata;
    err = pslverr;
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  // LUI/ORI pairs build a in r8 and b in r9
  task automatic put_operands(input int r, input logic [31:0] a, input logic [31:0] b);
    prog[r][0] = i_format(mips_pkg::op_lui, 0, 8, a[31:16]);
    prog[r][1] = i_format(mips_pkg::op_ori, 8, 8, a[15:0]);
    prog[r][2] = i_format(mips_pkg::op_lui, 0, 9, b[31:16]);
    prog[r][3] = i_format(mips_pkg::op_ori, 9, 9, b[15:0]);
  endtask

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    for (int r = 0; r < num_rows; r++) begin
      for (int i = 0; i < prog_len; i++) begin
        prog[r][i] = 32'd0;
      end
    end
    data_idx = '{8'h10, 8'h18, 8'h21, 8'h30, 8'h40, 8'h50};

    // Row 0 sum, difference and shift
    a = $urandom();
    b = $urandom();
    put_operands(0, a, b);
    prog[0][4] = r_format(8, 9, 10, 0, mips_pkg::fn_addu);
    prog[0][5] = r_format(8, 9, 11, 0, mips_pkg::fn_subu);
    prog[0][6] = r_format(10, 11, 2, 0, mips_pkg::fn_xor);
    prog[0][7] = r_format(0, 10, 12, 3, mips_pkg::fn_srl);
    prog[0][8] = i_format(mips_pkg::op_sw, 0, 12, {6'b0, data_idx[0], 2'b00});
    prog[0][9] = j_format(mips_pkg::op_j, 0);
    exp_v0[0] = (a + b) ^ (a - b);
    exp_data[0] = (a + b) >> 3;

    // Row 1 compares a negative a with a positive b both signed and unsigned
    a = $urandom() | 32'h8000_0000;
    b = $urandom() & 32'h7fff_ffff;
    put_operands(1, a, b);
    prog[1][4] = r_format(8, 9, 10, 0, mips_pkg::fn_slt);
    prog[1][5] = r_format(8, 9, 11, 0, mips_pkg::fn_sltu);
    prog[1][6] = r_format(0, 11, 11, 1, mips_pkg::fn_sll);
    prog[1][7] = r_format(10, 11, 2, 0, mips_pkg::fn_or);
    prog[1][8] = r_format(9, 8, 12, 0, mips_pkg::fn_slt);
    prog[1][9] = i_format(mips_pkg::op_sw, 0, 12, {6'b0, data_idx[1], 2'b00});
    prog[1][10] = j_format(mips_pkg::op_j, 0);
    exp_v0[1] = {30'b0, (a < b), ($signed(a) < $signed(b))};
    exp_data[1] = {31'b0, ($signed(b) < $signed(a))};

    // Row 2 store then load at byte address 0x84
    prog[2][0] = i_format(mips_pkg::op_lui, 0, 8, 16'h5a3c);
    prog[2][1] = i_format(mips_pkg::op_ori, 8, 8, 16'h96e1);
    prog[2][2] = i_format(mips_pkg::op_addiu, 0, 9, 16'h0080);
    prog[2][3] = i_format(mips_pkg::op_sw, 9, 8, 16'd4);
    prog[2][4] = i_format(mips_pkg::op_lw, 9, 2, 16'd4);
    prog[2][5] = j_format(mips_pkg::op_j, 0);
    exp_v0[2] = 32'h5a3c_96e1;
    exp_data[2] = 32'h5a3c_96e1;

    // Row 3 skipped words add 0x10 so any stray one shows in v0
    prog[3][0] = i_format(mips_pkg::op_beq, 0, 0, 16'd3);
    prog[3][1] = i_format(mips_pkg::op_addiu, 2, 2, 16'd1);
    prog[3][2] = i_format(mips_pkg::op_addiu, 2, 2, 16'h10);
    prog[3][3] = i_format(mips_pkg::op_addiu, 2, 2, 16'h10);
    prog[3][4] = i_format(mips_pkg::op_bne, 0, 0, 16'd5);
    prog[3][5] = i_format(mips_pkg::op_addiu, 2, 2, 16'd1);
    prog[3][6] = i_format(mips_pkg::op_addiu, 2, 2, 16'd1);
    prog[3][7] = j_format(mips_pkg::op_j, 10);
    prog[3][8] = i_format(mips_pkg::op_addiu, 2, 2, 16'd1);
    prog[3][9] = i_format(mips_pkg::op_addiu, 2, 2, 16'h10);
    prog[3][10] = j_format(mips_pkg::op_j, 0);
    prog[3][11] = i_format(mips_pkg::op_addiu, 2, 2, 16'd1);
    exp_v0[3] = 32'd5;
    exp_data[3] = sentinel;

    // Row 4 calls word 6 and returns through the link of 8 to word 2
    prog[4][0] = j_format(mips_pkg::op_jal, 6);
    prog[4][1] = i_format(mips_pkg::op_addiu, 2, 2, 16'h0001);
    prog[4][2] = i_format(mips_pkg::op_addiu, 2, 2, 16'h0100);
    prog[4][3] = j_format(mips_pkg::op_j, 0);
    prog[4][4] = i_format(mips_pkg::op_addiu, 2, 2, 16'h1000);
    prog[4][6] = i_format(mips_pkg::op_sw, 0, 31, {6'b0, data_idx[4], 2'b00});
    prog[4][7] = r_format(31, 0, 0, 0, mips_pkg::fn_jr);
    prog[4][8] = i_format(mips_pkg::op_addiu, 2, 2, 16'h0010);
    exp_v0[4] = 32'h0000_1111;
    exp_data[4] = 32'd8;

    // Row 5 countdown loop keeps the core busy across many polls
    prog[5][0] = i_format(mips_pkg::op_addiu, 0, 8, 16'd40);
    prog[5][1] = i_format(mips_pkg::op_addiu, 8, 8, 16'hffff);
    prog[5][2] = i_format(mips_pkg::op_bne, 8, 0, 16'hfffe);
    prog[5][3] = i_format(mips_pkg::op_addiu, 2, 2, 16'd1);
    prog[5][4] = j_format(mips_pkg::op_j, 0);
    prog[5][5] = i_format(mips_pkg::op_sw, 0, 2, {6'b0, data_idx[5], 2'b00});
    exp_v0[5] = 32'd40;
    exp_data[5] = 32'd40;
  endtask

  task automatic run_row(input int r);
    logic [31:0] status;
    logic [31:0] rdata;
    logic err;
    int polls;
    apb_write(mips_pkg::reg_mem_addr, 32'h0);
    for (int i = 0; i < prog_len; i++) begin
      apb_write(mips_pkg::reg_mem_data, prog[r][i]);
    end
    // Mark the data word so a missing store is caught
    apb_write(mips_pkg::reg_mem_addr, {23'b0, 1'b1, data_idx[r]});
    apb_write(mips_pkg::reg_mem_data, sentinel);
    apb_write(mips_pkg::reg_ctrl, 32'h1);

    apb_read(mips_pkg::reg_status, status, err);
    check_value($sformatf("row %0d status at start", r), status, 32'h1);
    apb_read(mips_pkg::reg_mem_data, rdata, err);
    check_value($sformatf("row %0d pslverr on window during run", r), {31'b0, err}, 32'h1);

    polls = 0;
    while (!status[1] && polls < poll_limit) begin
      apb_read(mips_pkg::reg_status, status, err);
      polls++;
      if (!status[1]) begin
        check_value($sformatf("row %0d status while running", r), status, 32'h1);
      end
    end
    checks++;
    assert (status[1]) else begin
      $display("Row %0d: the core did not report done within %0d status polls", r, poll_limit);
      errors++;
    end
    if (status[1]) begin
      check_value($sformatf("row %0d status when done", r), status, 32'h2);
    end

    apb_read(mips_pkg::reg_v0, rdata, err);
    check_value($sformatf("row %0d v0", r), rdata, exp_v0[r]);
    apb_write(mips_pkg::reg_ctrl, 32'h0);
    apb_read(mips_pkg::reg_status, status, err);
    check_value($sformatf("row %0d status after stop", r), status, 32'h0);
    apb_write(mips_pkg::reg_mem_addr, {23'b0, 1'b1, data_idx[r]});
    apb_read(mips_pkg::reg_mem_data, rdata, err);
    check_value($sformatf("row %0d data word", r), rdata, exp_data[r]);
  endtask

  initial begin
    logic [31:0] rdata;
    logic err;
    reset = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    void'($urandom(36218));
    build_table();

    repeat (4) @(posedge clk);
    reset <= 1'b0;
    check_value("prdata after reset", prdata, 32'h0);
    check_value("pslverr after reset", {31'b0, pslverr}, 32'h0);
    apb_read(mips_pkg::reg_ctrl, rdata, err);
    check_value("ctrl after reset", rdata, 32'h0);
    // 0x14 lies past the last register
    apb_read(8'h14, rdata, err);
    check_value("pslverr on unmapped read", {31'b0, err}, 32'h1);

    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: mips_soc.f
rtl/mips_pkg.sv
rtl/mips_alu.sv
rtl/mips_decoder.sv
rtl/mips_regfile.sv
rtl/mips_cpu_harvard.sv
rtl/soc_mem.sv
rtl/soc_ctrl_apb.sv
rtl/mips_soc.sv
dv/mips_soc_tb.sv

// File: rtl/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
  input  mips_pkg::alu_op_t alu_op,
  input  logic [31:0]       operand_a,
  input  logic [31:0]       operand_b,
  input  logic [4:0]        shamt,
  output logic [31:0]       result,
  output logic              equal
);

  always_comb begin
    case (alu_op)
      mips_pkg::add: begin
        result = operand_a + operand_b;
      end
      mips_pkg::sub: begin
        result = operand_a - operand_b;
      end
      mips_pkg::and_op: begin
        result = operand_a & operand_b;
      end
      mips_pkg::or_op: begin
        result = operand_a | operand_b;
      end
      mips_pkg::xor_op: begin
        result = operand_a ^ operand_b;
      end
      mips_pkg::slt: begin
        result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      end
      mips_pkg::sltu: begin
        result = {31'b0, operand_a < operand_b};
      end
      // Shifts act on rt, which arrives as operand_b
      mips_pkg::sll: begin
        result = operand_b << shamt;
      end
      mips_pkg::srl: begin
        result = operand_b >> shamt;
      end
      mips_pkg::lui: begin
        result = {operand_b[15:0], 16'b0};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // Branch decision for BEQ and BNE
  assign equal = (operand_a == operand_b);

endmodule

// File: rtl/mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  output logic        active,
  output logic [31:0] register_v0,
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  logic [mips_pkg::word_w-1:0] pc, pc_plus4, pc_plus8, next_pc;
  logic [mips_pkg::word_w-1:0] pend_target, take_target, branch_target, jump_target;
  logic [mips_pkg::word_w-1:0] imm_ext, rs_data, rt_data, alu_b, alu_result, wb_data;
  logic [mips_pkg::reg_addr_w-1:0] dest;
  logic pend_valid, stepped, halt_fetch, step, taken, equal;

  logic reg_write, reg_dst_rd, reg_dst_ra, alu_src_imm, imm_zero_ext;
  logic mem_read, mem_write, branch_eq, branch_ne, jump, jump_reg;
  mips_pkg::alu_op_t alu_op;
  mips_pkg::wb_sel_t wb_sel;

  mips_decoder u_decoder (
    .opcode       (instr_readdata[31:26]),
    .funct        (instr_readdata[5:0]),
    .reg_write    (reg_write),
    .reg_dst_rd   (reg_dst_rd),
    .reg_dst_ra   (reg_dst_ra),
    .alu_src_imm  (alu_src_imm),
    .imm_zero_ext (imm_zero_ext),
    .alu_op       (alu_op),
    .wb_sel       (wb_sel),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .branch_eq    (branch_eq),
    .branch_ne    (branch_ne),
    .jump         (jump),
    .jump_reg     (jump_reg)
  );

  // A fetch from zero after the first step is the halt
  assign halt_fetch = stepped && (pc == '0);
  assign step = clk_enable && !halt_fetch;

  assign pc_plus4 = pc + 32'd4;
  assign pc_plus8 = pc + 32'd8;
  assign instr_address = pc;

  assign imm_ext = imm_zero_ext ? {16'b0, instr_readdata[15:0]}
                                : {{16{instr_readdata[15]}}, instr_readdata[15:0]};
  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign jump_target = {pc_plus4[31:28], instr_readdata[25:0], 2'b00};

  assign taken = jump || jump_reg || (branch_eq && equal) || (branch_ne && !equal);

  always_comb begin
    if (jump_reg) begin
      take_target = rs_data;
    end else if (jump) begin
      take_target = jump_target;
    end else begin
      take_target = branch_target;
    end
  end

  // Delay slot runs first, the stored target comes one fetch later
  assign next_pc = pend_valid ? pend_target : pc_plus4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      pend_valid <= 1'b0;
      stepped <= 1'b0;
      active <= 1'b1;
    end else if (clk_enable) begin
      if (halt_fetch) begin
        active <= 1'b0;
      end else begin
        pc <= next_pc;
        pend_valid <= taken;
        stepped <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step && taken) begin
      pend_target <= take_target;
    end
  end

  always_comb begin
    if (reg_dst_ra) begin
      dest = 5'd31;
    end else if (reg_dst_rd) begin
      dest = instr_readdata[15:11];
    end else begin
      dest = instr_readdata[20:16];
    end
  end

  mips_regfile u_regfile (
    .clk         (clk),
    .reset       (reset),
    .read_addr_a (instr_readdata[25:21]),
    .read_addr_b (instr_readdata[20:16]),
    .write_en    (reg_write && step),
    .write_addr  (dest),
    .write_data  (wb_data),
    .read_data_a (rs_data),
    .read_data_b (rt_data),
    .register_v0 (register_v0)
  );

  assign alu_b = alu_src_imm ? imm_ext : rt_data;

  mips_alu u_alu (
    .alu_op    (alu_op),
    .operand_a (rs_data),
    .operand_b (alu_b),
    .shamt     (instr_readdata[10:6]),
    .result    (alu_result),
    .equal     (equal)
  );

  always_comb begin
    case (wb_sel)
      mips_pkg::mem:  wb_data = data_readdata;
      mips_pkg::link: wb_data = pc_plus8;
      default:        wb_data = alu_result;
    endcase
  end

  assign data_address = alu_result;
  assign data_writedata = rt_data;
  assign data_write = mem_write && step;
  assign data_read = mem_read && step;

endmodule

// File: rtl/mips_decoder.sv
`timescale 1ns/1ps

module mips_decoder (
  input  logic [5:0]        opcode,
  input  logic [5:0]        funct,
  output logic              reg_write,
  output logic              reg_dst_rd,
  output logic              reg_dst_ra,
  output logic              alu_src_imm,
  output logic              imm_zero_ext,
  output mips_pkg::alu_op_t alu_op,
  output mips_pkg::wb_sel_t wb_sel,
  output logic              mem_read,
  output logic              mem_write,
  output logic              branch_eq,
  output logic              branch_ne,
  output logic              jump,
  output logic              jump_reg
);

  always_comb begin
    // Anything not listed falls through as a NOP
    reg_write = 1'b0;
    reg_dst_rd = 1'b0;
    reg_dst_ra = 1'b0;
    alu_src_imm = 1'b0;
    imm_zero_ext = 1'b0;
    alu_op = mips_pkg::add;
    wb_sel = mips_pkg::alu;
    mem_read = 1'b0;
    mem_write = 1'b0;
    branch_eq = 1'b0;
    branch_ne = 1'b0;
    jump = 1'b0;
    jump_reg = 1'b0;

    case (opcode)
      mips_pkg::op_special: begin
        reg_dst_rd = 1'b1;
        reg_write = 1'b1;
        case (funct)
          mips_pkg::fn_sll:  alu_op = mips_pkg::sll;
          mips_pkg::fn_srl:  alu_op = mips_pkg::srl;
          mips_pkg::fn_addu: alu_op = mips_pkg::add;
          mips_pkg::fn_subu: alu_op = mips_pkg::sub;
          mips_pkg::fn_and:  alu_op = mips_pkg::and_op;
          mips_pkg::fn_or:   alu_op = mips_pkg::or_op;
          mips_pkg::fn_xor:  alu_op = mips_pkg::xor_op;
          mips_pkg::fn_slt:  alu_op = mips_pkg::slt;
          mips_pkg::fn_sltu: alu_op = mips_pkg::sltu;
          mips_pkg::fn_jr: begin
            reg_write = 1'b0;
            jump_reg = 1'b1;
          end
          default: reg_write = 1'b0;
        endcase
      end
      mips_pkg::op_j: jump = 1'b1;
      mips_pkg::op_jal: begin
        jump = 1'b1;
        reg_write = 1'b1;
        reg_dst_ra = 1'b1;
        wb_sel = mips_pkg::link;
      end
      // Branches compare rs against rt through the ALU
      mips_pkg::op_beq: branch_eq = 1'b1;
      mips_pkg::op_bne: branch_ne = 1'b1;
      mips_pkg::op_addiu: begin
        reg_write = 1'b1;
        alu_src_imm = 1'b1;
      end
      mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori: begin
        reg_write = 1'b1;
        alu_src_imm = 1'b1;
        imm_zero_ext = 1'b1;
        if (opcode == mips_pkg::op_andi) begin
          alu_op = mips_pkg::and_op;
        end else if (opcode == mips_pkg::op_ori) begin
          alu_op = mips_pkg::or_op;
        end else begin
          alu_op = mips_pkg::xor_op;
        end
      end
      mips_pkg::op_lui: begin
        reg_write = 1'b1;
        alu_src_imm = 1'b1;
        alu_op = mips_pkg::lui;
      end
      mips_pkg::op_lw: begin
        reg_write = 1'b1;
        alu_src_imm = 1'b1;
        mem_read = 1'b1;
        wb_sel = mips_pkg::mem;
      end
      mips_pkg::op_sw: begin
        alu_src_imm = 1'b1;
        mem_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

  // Datapath widths and memory sizes
  localparam int word_w = 32;
  localparam int reg_addr_w = 5;
  localparam int imem_depth = 256;
  localparam int dmem_depth = 256;

  // Primary opcodes
  localparam logic [5:0] op_special = 6'd0;
  localparam logic [5:0] op_j = 6'd2;
  localparam logic [5:0] op_jal = 6'd3;
  localparam logic [5:0] op_beq = 6'd4;
  localparam logic [5:0] op_bne = 6'd5;
  localparam logic [5:0] op_addiu = 6'd9;
  localparam logic [5:0] op_andi = 6'd12;
  localparam logic [5:0] op_ori = 6'd13;
  localparam logic [5:0] op_xori = 6'd14;
  localparam logic [5:0] op_lui = 6'd15;
  localparam logic [5:0] op_lw = 6'd35;
  localparam logic [5:0] op_sw = 6'd43;

  // Function codes under op_special
  localparam logic [5:0] fn_sll = 6'd0;
  localparam logic [5:0] fn_srl = 6'd2;
  localparam logic [5:0] fn_jr = 6'd8;
  localparam logic [5:0] fn_addu = 6'd33;
  localparam logic [5:0] fn_subu = 6'd35;
  localparam logic [5:0] fn_and = 6'd36;
  localparam logic [5:0] fn_or = 6'd37;
  localparam logic [5:0] fn_xor = 6'd38;
  localparam logic [5:0] fn_slt = 6'd42;
  localparam logic [5:0] fn_sltu = 6'd43;

  typedef enum logic [3:0] {
    add, sub, and_op, or_op, xor_op, slt, sltu, sll, srl, lui
  } alu_op_t;

  // Link returns PC plus 8
  typedef enum logic [1:0] {alu, mem, link} wb_sel_t;

  // APB register map
  localparam int apb_addr_w = 8;
  localparam logic [apb_addr_w-1:0] reg_ctrl = 8'h00;
  localparam logic [apb_addr_w-1:0] reg_status = 8'h04;
  localparam logic [apb_addr_w-1:0] reg_v0 = 8'h08;
  localparam logic [apb_addr_w-1:0] reg_mem_addr = 8'h0C;
  localparam logic [apb_addr_w-1:0] reg_mem_data = 8'h10;

endpackage

// File: rtl/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  read_addr_a,
  input  logic [4:0]  read_addr_b,
  input  logic        write_en,
  input  logic [4:0]  write_addr,
  input  logic [31:0] write_data,
  output logic [31:0] read_data_a,
  output logic [31:0] read_data_b,
  output logic [31:0] register_v0
);

  logic [mips_pkg::word_w-1:0] regs [2**mips_pkg::reg_addr_w];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**mips_pkg::reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (write_addr != '0)) begin
      // r0 never takes a write so it stays zero
      regs[write_addr] <= write_data;
    end
  end

  assign read_data_a = regs[read_addr_a];
  assign read_data_b = regs[read_addr_b];

  // v0 is r2
  assign register_v0 = regs[2];

endmodule

// File: rtl/mips_soc.sv
`timescale 1ns/1ps

module mips_soc (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [mips_pkg::apb_addr_w-1:0] paddr,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr
);

  logic run, active, data_write, data_read;
  logic win_we, win_sel_data, dmem_we;
  logic [7:0] win_index, imem_read_index, dmem_read_index, dmem_write_index;
  logic [31:0] register_v0, instr_address, instr_readdata;
  logic [31:0] data_address, data_writedata, data_readdata;
  logic [31:0] win_wdata, win_rdata, dmem_rdata, dmem_write_data;

  soc_ctrl_apb u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .active       (active),
    .register_v0  (register_v0),
    .mem_rdata    (win_rdata),
    .run          (run),
    .mem_we       (win_we),
    .mem_sel_data (win_sel_data),
    .mem_index    (win_index),
    .mem_wdata    (win_wdata)
  );

  // Core is held in reset whenever run is clear
  mips_cpu_harvard u_cpu (
    .clk            (clk),
    .reset          (reset || !run),
    .clk_enable     (active),
    .active         (active),
    .register_v0    (register_v0),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  // Run hands the memory ports from the window to the core
  assign imem_read_index = run ? instr_address[9:2] : win_index;
  assign dmem_read_index = run ? data_address[9:2] : win_index;
  assign dmem_write_index = run ? data_address[9:2] : win_index;
  assign dmem_we = run ? data_write : (win_we && win_sel_data);
  assign dmem_write_data = run ? data_writedata : win_wdata;

  soc_mem #(.depth(mips_pkg::imem_depth)) u_imem (
    .clk         (clk),
    .read_index  (imem_read_index),
    .write_en    (win_we && !win_sel_data && !run),
    .write_index (win_index),
    .write_data  (win_wdata),
    .read_data   (instr_readdata)
  );

  soc_mem #(.depth(mips_pkg::dmem_depth)) u_dmem (
    .clk         (clk),
    .read_index  (dmem_read_index),
    .write_en    (dmem_we),
    .write_index (dmem_write_index),
    .write_data  (dmem_write_data),
    .read_data   (dmem_rdata)
  );

  assign data_readdata = data_read ? dmem_rdata : '0;
  assign win_rdata = win_sel_data ? dmem_rdata : instr_readdata;

endmodule

// File: rtl/soc_ctrl_apb.sv
`timescale 1ns/1ps

module soc_ctrl_apb (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [mips_pkg::apb_addr_w-1:0] paddr,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  input  logic                          active,
  input  logic [31:0]                   register_v0,
  input  logic [31:0]                   mem_rdata,
  output logic                          run,
  output logic                          mem_we,
  output logic                          mem_sel_data,
  output logic [7:0]                    mem_index,
  output logic [31:0]                   mem_wdata
);

  logic done, setup, access, win_reg, mapped, err;
  logic [8:0] win_addr;
  logic [31:0] rd_val;

  assign setup = psel && !penable;
  assign access = psel && penable;

  // Core freezes after the halt, so done lasts until run clears
  assign done = run && !active;

  always_comb begin
    win_reg = (paddr == mips_pkg::reg_mem_addr) || (paddr == mips_pkg::reg_mem_data);
    mapped = win_reg || (paddr == mips_pkg::reg_ctrl) || (paddr == mips_pkg::reg_status)
             || (paddr == mips_pkg::reg_v0);
    // Window belongs to the core while it runs
    err = !mapped || (win_reg && run);
    case (paddr)
      mips_pkg::reg_ctrl:     rd_val = {31'b0, run};
      mips_pkg::reg_status:   rd_val = {30'b0, done, run && active};
      mips_pkg::reg_v0:       rd_val = register_v0;
      mips_pkg::reg_mem_addr: rd_val = {23'b0, win_addr};
      mips_pkg::reg_mem_data: rd_val = mem_rdata;
      default:                rd_val = '0;
    endcase
    if (err) begin
      rd_val = '0;
    end
  end

  assign pready = 1'b1;
  assign mem_we = access && pwrite && !err && (paddr == mips_pkg::reg_mem_data);
  assign mem_index = win_addr[7:0];
  assign mem_sel_data = win_addr[8];
  assign mem_wdata = pwdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      run <= 1'b0;
      win_addr <= '0;
      prdata <= '0;
      pslverr <= 1'b0;
    end else begin
      if (access && pwrite && !err) begin
        if (paddr == mips_pkg::reg_ctrl) begin
          run <= pwdata[0];
        end else if (paddr == mips_pkg::reg_mem_addr) begin
          win_addr <= pwdata[8:0];
        end
      end
      // Data port steps the word index on every access
      if (access && !err && (paddr == mips_pkg::reg_mem_data)) begin
        win_addr[7:0] <= win_addr[7:0] + 8'd1;
      end
      // Response is captured in setup and held through the access phase
      if (setup) begin
        prdata <= rd_val;
        pslverr <= err;
      end else if (!access) begin
        prdata <= '0;
        pslverr <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/soc_mem.sv
`timescale 1ns/1ps

module soc_mem #(
  parameter int depth = 256
) (
  input  logic                     clk,
  input  logic [$clog2(depth)-1:0] read_index,
  input  logic                     write_en,
  input  logic [$clog2(depth)-1:0] write_index,
  input  logic [31:0]              write_data,
  output logic [31:0]              read_data
);

  logic [mips_pkg::word_w-1:0] store [depth];

  always_ff @(posedge clk) begin
    if (write_en) begin
      store[write_index] <= write_data;
    end
  end

  // Same-cycle read, as the core expects
  assign read_data = store[read_index];

endmodule
